//--- compile.f
+incdir+.
host_io_pkg.sv
io_frame_if.sv
io_framer.sv
user_cmd_decoder.sv
ps2_key_decoder.sv
file_loader.sv
host_io_core.sv
tb_host_io_core.sv

//--- Bender.yml
package:
  name: host_io_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - host_io_pkg.sv
      - io_frame_if.sv
      - io_framer.sv
      - user_cmd_decoder.sv
      - ps2_key_decoder.sv
      - file_loader.sv
      - host_io_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_host_io_core.sv

//--- tb_host_io_core.sv
// assumes results 2 cycles after each strobe and frames of at most four payload words
`default_nettype none

`include "host_io_defines.svh"

module tb_host_io_core;

	localparam int CLK_PERIOD = 40;
	localparam int DLY        = 5;
	localparam int NUM_ROWS   = 16;

	// a frame to send and the outputs expected once it has ended
	typedef struct packed {
		logic             file_ch;
		logic [15:0]      cmd;
		logic [2:0]       nw;
		logic [3:0][15:0] w;
		logic [4:0][15:0] dout;
		logic [1:0]       buttons;
		logic [31:0]      joy0;
		logic [31:0]      joy1;
		logic [63:0]      status;
		logic [10:0]      key;
		logic [7:0]       index;
		logic             download;
		logic [26:0]      addr;
	} row_t;

	logic        clk_sys;
	logic        rst_n;
	logic        io_enable;
	logic        fp_enable;
	logic        io_strobe;
	logic [15:0] io_din;
	logic [15:0] io_dout;
	logic [1:0]  buttons;
	logic [31:0] joystick_0;
	logic [31:0] joystick_1;
	logic [63:0] status;
	logic [63:0] status_in;
	logic        status_set;
	logic [10:0] ps2_key;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [26:0] ioctl_addr;
	logic [7:0]  ioctl_dout;

	row_t        tbl [NUM_ROWS];
	row_t        st;
	int          nrows;
	logic [26:0] file_addr;
	logic [63:0] req_status;

	host_io_core UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// the longest frame takes about 25 cycles so 40 per row leaves margin
	initial begin
		#(NUM_ROWS * 40 * CLK_PERIOD);
		$display("watchdog expired before the frame table was finished");
		$display("Simulation failed");
		$fatal(1, "run stopped by watchdog");
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	//////////////////////////////////////////////////
	// table construction

	task automatic set_frame(input logic fch, input logic [15:0] cmd, input int nw,
		input logic [63:0] w);
		st.file_ch = fch;
		st.cmd     = cmd;
		st.nw      = 3'(nw);
		st.w       = w;
	endtask

	task automatic push_row();
		tbl[nrows] = st;
		nrows      = nrows + 1;
		st.dout    = '0;
	endtask

	task automatic build_table();
		logic [63:0] rnd;
		rnd = {$urandom, $urandom};
		set_frame(1'b0, `HOST_IO_CMD_CFG, 1, rnd);
		st.buttons = rnd[1:0];
		push_row();
		// joystick words go low half first
		rnd = {$urandom, $urandom};
		set_frame(1'b0, `HOST_IO_CMD_JOY0, 2, rnd);
		st.joy0 = rnd[31:0];
		push_row();
		rnd = {$urandom, $urandom};
		set_frame(1'b0, `HOST_IO_CMD_JOY1, 2, rnd);
		st.joy1 = rnd[31:0];
		push_row();
		rnd = {$urandom, $urandom};
		set_frame(1'b0, `HOST_IO_CMD_STATUS, 4, rnd);
		st.status = rnd;
		push_row();
		// short status frame only touches the low 32 bits
		rnd = {$urandom, $urandom};
		set_frame(1'b0, `HOST_IO_CMD_STATUS, 2, rnd);
		st.status = {st.status[63:32], rnd[31:0]};
		push_row();
		// tag A above a request count of 2 and then the captured slices
		set_frame(1'b0, `HOST_IO_CMD_STATUS_REQ, 4, 64'h0);
		st.dout = {req_status, 16'h00A2};
		push_row();

		//////////////////////////////////////////////////
		// keyboard events flip the toggle per accepted frame
		set_frame(1'b0, `HOST_IO_CMD_KBD, 1, 64'h001C);
		st.key = {1'b1, 1'b1, 1'b0, 8'h1C};
		push_row();
		set_frame(1'b0, `HOST_IO_CMD_KBD, 2, {16'h0075, 16'h00E0});
		st.key = {1'b0, 1'b1, 1'b1, 8'h75};
		push_row();
		set_frame(1'b0, `HOST_IO_CMD_KBD, 2, {16'h001C, 16'h00F0});
		st.key = {1'b1, 1'b0, 1'b0, 8'h1C};
		push_row();
		set_frame(1'b0, `HOST_IO_CMD_KBD, 4, 64'h007C_00E0_0012_00E0);
		st.key = {1'b0, 10'h37C};
		push_row();
		// a skip word leaves the event as it was
		set_frame(1'b0, `HOST_IO_CMD_KBD, 2, {16'hFF00, 16'h0033});
		push_row();

		// download channel
		set_frame(1'b1, `HOST_IO_CMD_FILE_INDEX, 1, 64'h0107);
		st.index = 8'h07;
		push_row();
		set_frame(1'b1, `HOST_IO_CMD_FILE_TX, 1, 64'h0001);
		st.download = 1'b1;
		push_row();
		set_frame(1'b1, `HOST_IO_CMD_FILE_DAT, 4, {$urandom, $urandom});
		st.addr = 27'd3;
		push_row();
		set_frame(1'b1, `HOST_IO_CMD_FILE_DAT, 3, {$urandom, $urandom});
		st.addr = 27'd6;
		push_row();
		set_frame(1'b1, `HOST_IO_CMD_FILE_TX, 1, 64'h0000);
		st.download = 1'b0;
		st.addr     = 27'd7;
		push_row();
	endtask

	//////////////////////////////////////////////////
	// frame driver and checks

	task automatic run_frame(input row_t f);
		int          wr_cnt;
		logic [15:0] word;
		logic        data_word;
		if (f.file_ch && f.cmd == `HOST_IO_CMD_FILE_TX && f.w[0][7:0] != 8'h00) begin
			file_addr = '0;
		end
		if (f.file_ch) begin
			fp_enable = 1'b1;
		end else begin
			io_enable = 1'b1;
		end
		@(posedge clk_sys);
		#DLY;
		for (int i = 0; i <= f.nw; i++) begin
			if (i == 0) begin
				word = f.cmd;
			end else begin
				word = f.w[i-1];
			end
			data_word = f.file_ch && f.cmd == `HOST_IO_CMD_FILE_DAT && i != 0;
			io_din    = word;
			io_strobe = 1'b1;
			wr_cnt    = 0;
			// strobes 4 cycles apart
			for (int c = 0; c < 4; c++) begin
				@(posedge clk_sys);
				#DLY;
				io_strobe = 1'b0;
				if (ioctl_wr) begin
					wr_cnt = wr_cnt + 1;
					check_value("ioctl_addr", ioctl_addr, file_addr);
					check_value("ioctl_dout", ioctl_dout, word[7:0]);
				end
				if (c == 1 && !f.file_ch) begin
					check_value("io_dout", io_dout, f.dout[i]);
				end
			end
			check_value("ioctl_wr pulse count", wr_cnt, data_word);
			if (data_word) begin
				file_addr = file_addr + 1'b1;
			end
		end
		io_enable = 1'b0;
		fp_enable = 1'b0;
		repeat (4) @(posedge clk_sys);
		#DLY;
	endtask

	task automatic check_state(input row_t e);
		check_value("buttons", buttons, e.buttons);
		check_value("joystick_0", joystick_0, e.joy0);
		check_value("joystick_1", joystick_1, e.joy1);
		check_value("status", status, e.status);
		check_value("ps2_key", ps2_key, e.key);
		check_value("ioctl_index", ioctl_index, e.index);
		check_value("ioctl_download", ioctl_download, e.download);
		check_value("ioctl_addr", ioctl_addr, e.addr);
		check_value("io_dout", io_dout, 16'h0000);
		check_value("ioctl_wr", ioctl_wr, 1'b0);
	endtask

	task automatic pulse_status_set(input logic [63:0] value);
		status_in  = value;
		status_set = 1'b1;
		@(posedge clk_sys);
		#DLY;
		status_set = 1'b0;
		@(posedge clk_sys);
		#DLY;
	endtask

	initial begin
		void'($urandom(32'h8178_b5ae));
		rst_n      = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		st         = '0;
		nrows      = 0;
		file_addr  = '0;
		repeat (5) @(posedge clk_sys);
		#DLY;
		rst_n = 1'b1;
		@(posedge clk_sys);
		#DLY;
		check_state('0);
		// two request edges where only the last capture is read back
		pulse_status_set({$urandom, $urandom});
		req_status = {$urandom, $urandom};
		pulse_status_set(req_status);
		status_in = ~req_status;
		build_table();
		for (int i = 0; i < nrows; i++) begin
			run_frame(tbl[i]);
			check_state(tbl[i]);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- host_io_core.sv
// user and file channels share io_strobe and io_din; the host must not raise both enables at once
`default_nettype none

`include "host_io_defines.svh"

module host_io_core (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       io_enable,
	input  logic                       fp_enable,
	input  logic                       io_strobe,
	input  logic [`HOST_IO_WORD_W-1:0] io_din,
	output logic [`HOST_IO_WORD_W-1:0] io_dout,
	output logic [1:0]                 buttons,
	output logic [31:0]                joystick_0,
	output logic [31:0]                joystick_1,
	output logic [63:0]                status,
	input  logic [63:0]                status_in,
	input  logic                       status_set,
	output logic [10:0]                ps2_key,
	output logic                       ioctl_download,
	output logic [7:0]                 ioctl_index,
	output logic                       ioctl_wr,
	output logic [`HOST_IO_ADDR_W-1:0] ioctl_addr,
	output logic [7:0]                 ioctl_dout
);

	io_frame_if user_frame ();
	io_frame_if file_frame ();

	//////////////////////////////////////////////////
	// framing, one per channel enable
	io_framer u_user_framer (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.enable  (io_enable),
		.strobe  (io_strobe),
		.din     (io_din),
		.frame   (user_frame.src)
	);

	io_framer u_file_framer (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.enable  (fp_enable),
		.strobe  (io_strobe),
		.din     (io_din),
		.frame   (file_frame.src)
	);

	//////////////////////////////////////////////////
	// decode stages
	user_cmd_decoder u_user_cmd (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.frame      (user_frame.dst),
		.status_in  (status_in),
		.status_set (status_set),
		.buttons    (buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.io_dout    (io_dout)
	);

	ps2_key_decoder u_ps2_key (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.frame   (user_frame.dst),
		.ps2_key (ps2_key)
	);

	file_loader u_file_loader (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.frame          (file_frame.dst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

`default_nettype wire

//--- file_loader.sv
// byte-wide downloads only; the host is never stalled so the sink must take every ioctl_wr
`default_nettype none

`include "host_io_defines.svh"

module file_loader import host_io_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	io_frame_if.dst    frame,
	output logic       ioctl_download,
	output logic [7:0] ioctl_index,
	output logic       ioctl_wr,
	output file_addr_t ioctl_addr,
	output logic [7:0] ioctl_dout
);

	file_addr_t addr;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			addr           <= '0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (frame.word_valid && frame.word_idx != '0) begin
				case (frame.cmd)
					`HOST_IO_CMD_FILE_INDEX: begin
						ioctl_index <= frame.word[7:0];
					end
					`HOST_IO_CMD_FILE_TX: begin
						if (frame.word[7:0] != 8'h00) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// final byte count on end of download
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end
					`HOST_IO_CMD_FILE_DAT: begin
						ioctl_addr <= addr;
						ioctl_dout <= frame.word[7:0];
						ioctl_wr   <= 1'b1;
						addr       <= addr + 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- ps2_key_decoder.sv
// only the last four keyboard bytes of a frame are kept; one event is produced per frame
`default_nettype none

`include "host_io_defines.svh"

module ps2_key_decoder import host_io_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	io_frame_if.dst    frame,
	output key_event_t ps2_key
);

	logic [31:0] key_raw;
	logic        skip;
	logic        kbd_frame;
	key_event_t  key_next;

	assign kbd_frame = (frame.cmd == `HOST_IO_CMD_KBD);

	// decode the byte history into the next event
	always_comb begin
		key_next.toggle   = ~ps2_key.toggle;
		key_next.code     = key_raw[7:0];
		key_next.pressed  = (key_raw[15:8] != 8'hF0);
		// on release the E0 prefix sits before the F0
		key_next.extended = key_next.pressed ? (key_raw[15:8] == 8'hE0)
			: (key_raw[23:16] == 8'hE0);
		case (key_raw)
			32'hE012E07C: {key_next.pressed, key_next.extended, key_next.code} = 10'h37C;
			32'h7CE0F012: {key_next.pressed, key_next.extended, key_next.code} = 10'h17C;
			32'hF014F077: {key_next.pressed, key_next.extended, key_next.code} = 10'h377;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			key_raw <= '0;
			skip    <= 1'b0;
			ps2_key <= '0;
		end else if (frame.frame_end) begin
			if (kbd_frame && !skip) begin
				ps2_key <= key_next;
			end
			skip <= 1'b0;
		end else if (frame.word_valid) begin
			if (frame.word_idx == '0) begin
				key_raw <= '0;
				skip    <= 1'b0;
			end else if (kbd_frame) begin
				// high byte all ones marks a frame to ignore
				if (&frame.word[15:8]) begin
					skip <= 1'b1;
				end else if (!skip) begin
					key_raw <= {key_raw[23:0], frame.word[7:0]};
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- user_cmd_decoder.sv
// captured status reads back as X until the first status_set edge; io_dout holds between words
`default_nettype none

`include "host_io_defines.svh"

module user_cmd_decoder import host_io_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	io_frame_if.dst    frame,
	input  status_t    status_in,
	input  logic       status_set,
	output logic [1:0] buttons,
	output joy_t       joystick_0,
	output joy_t       joystick_1,
	output status_t    status,
	output io_word_t   io_dout
);

	io_word_t   cfg;
	status_t    status_req;
	logic [3:0] req_cnt;
	logic       status_set_q;
	logic       quad_hit;
	logic [5:0] quad_lsb;

	assign buttons = cfg[1:0];

	// payload words 1 to 4 select the 16-bit slices of a 64-bit value from the lowest up
	assign quad_hit = (frame.word_idx >= io_idx_t'(1)) && (frame.word_idx <= io_idx_t'(4));
	assign quad_lsb = {2'(frame.word_idx - io_idx_t'(1)), 4'b0000};

	//////////////////////////////////////////////////
	// status request from the core side
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			status_set_q <= 1'b0;
			req_cnt      <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				req_cnt <= req_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_q) begin
			status_req <= status_in;
		end
	end

	//////////////////////////////////////////////////
	// host writes and readback
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			io_dout    <= '0;
		end else if (frame.frame_end) begin
			io_dout <= '0;
		end else if (frame.word_valid) begin
			io_dout <= '0;
			if (frame.word_idx == '0) begin
				// tag nibble above the request count
				if (frame.word == `HOST_IO_CMD_STATUS_REQ) begin
					io_dout <= {8'h00, `HOST_IO_STREQ_TAG, req_cnt};
				end
			end else begin
				case (frame.cmd)
					`HOST_IO_CMD_CFG: begin
						cfg <= frame.word;
					end
					`HOST_IO_CMD_JOY0: begin
						if (frame.word_idx == io_idx_t'(1)) begin
							joystick_0[15:0] <= frame.word;
						end else if (frame.word_idx == io_idx_t'(2)) begin
							joystick_0[31:16] <= frame.word;
						end
					end
					`HOST_IO_CMD_JOY1: begin
						if (frame.word_idx == io_idx_t'(1)) begin
							joystick_1[15:0] <= frame.word;
						end else if (frame.word_idx == io_idx_t'(2)) begin
							joystick_1[31:16] <= frame.word;
						end
					end
					`HOST_IO_CMD_STATUS: begin
						if (quad_hit) begin
							status[quad_lsb +: 16] <= frame.word;
						end
					end
					`HOST_IO_CMD_STATUS_REQ: begin
						if (quad_hit) begin
							io_dout <= status_req[quad_lsb +: 16];
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- io_framer.sv
// strobes seen with enable low are dropped; a frame with no words produces no frame_end
`default_nettype none

module io_framer import host_io_pkg::*; (
	input  logic     clk_sys,
	input  logic     rst_n,
	input  logic     enable,
	input  logic     strobe,
	input  io_word_t din,
	io_frame_if.src  frame
);

	io_idx_t word_cnt;
	logic    seen;

	//////////////////////////////////////////////////
	// frame control
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			word_cnt         <= '0;
			seen             <= 1'b0;
			frame.word_valid <= 1'b0;
			frame.frame_end  <= 1'b0;
			frame.cmd        <= '0;
		end else begin
			frame.word_valid <= enable & strobe;
			// enable dropped after at least one word
			frame.frame_end  <= ~enable & seen;
			if (!enable) begin
				word_cnt <= '0;
				seen     <= 1'b0;
			end else if (strobe) begin
				seen <= 1'b1;
				if (word_cnt == '0) begin
					frame.cmd <= din;
				end
				// saturate so long frames stay on the last index
				if (word_cnt != '1) begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

	// word payload
	always_ff @(posedge clk_sys) begin
		if (enable && strobe) begin
			frame.word     <= din;
			frame.word_idx <= word_cnt;
		end
	end

endmodule

`default_nettype wire

//--- io_frame_if.sv
// one framed host channel; word and word_idx are only meaningful while word_valid is high
`default_nettype none

interface io_frame_if import host_io_pkg::*; ();

	logic     word_valid;
	io_idx_t  word_idx;
	io_word_t cmd;
	io_word_t word;
	logic     frame_end;

	// framer side
	modport src (
		output word_valid, word_idx, cmd, word, frame_end
	);

	// decode stages
	modport dst (
		input word_valid, word_idx, cmd, word, frame_end
	);

endinterface

`default_nettype wire

//--- host_io_pkg.sv
// shared host interface types; widths come from the defines header and are fixed per build
`default_nettype none

package host_io_pkg;

`include "host_io_defines.svh"

	// one host bus word and its position in a frame
	typedef logic [`HOST_IO_WORD_W-1:0] io_word_t;
	typedef logic [`HOST_IO_CNT_W-1:0]  io_idx_t;

	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;

	// key event as seen by the core, toggle flips per event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_event_t;

	typedef logic [`HOST_IO_ADDR_W-1:0] file_addr_t;

endpackage

`default_nettype wire

//--- host_io_defines.svh
// host command codes and widths; codes are 16-bit so they compare directly against a host word
`ifndef HOST_IO_DEFINES_SVH
`define HOST_IO_DEFINES_SVH

//////////////////////////////////////////////////
// widths

`define HOST_IO_WORD_W 16
// word index saturates at all ones
`define HOST_IO_CNT_W 8
`define HOST_IO_ADDR_W 27

//////////////////////////////////////////////////
// command words, user channel

`define HOST_IO_CMD_CFG        16'h0001
`define HOST_IO_CMD_JOY0       16'h0002
`define HOST_IO_CMD_JOY1       16'h0003
`define HOST_IO_CMD_KBD        16'h0005
`define HOST_IO_CMD_STATUS     16'h001E
`define HOST_IO_CMD_STATUS_REQ 16'h0029

// command words, file channel
`define HOST_IO_CMD_FILE_TX    16'h0053
`define HOST_IO_CMD_FILE_DAT   16'h0054
`define HOST_IO_CMD_FILE_INDEX 16'h0055

// upper nibble of the status request readback
`define HOST_IO_STREQ_TAG 4'hA

`endif
